// File: acq_capture.f
src/acq_pkg.sv
src/acq_control.sv
src/sample_decimator.sv
src/axis_packetizer.sv
src/packet_fifo.sv
src/acq_top.sv
tests/acq_assertions.sv
tests/acq_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the acq_capture testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
top=acq_tb

verilator --binary --timing --assert -j 0 \
  --top-module "$top" \
  -Mdir "$build_dir" \
  -f acq_capture.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

"./$build_dir/V$top" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$log_file"; then
  echo "Testbench reported a failure, see $log_file"
  exit 1
fi

echo "Testbench reported no failure"
exit 0

// File: src/acq_control.sv
`timescale 1ns/1ns

module acq_control
  import acq_pkg::*;
(
  input  logic     aclk,
  input  logic     aresetn,

  input  logic     start,
  input  logic     stop,
  input  acq_cfg_t cfg,

  input  logic     pkt_done,
  input  logic     pkt_active,

  output logic     run,
  output logic     capture_en,
  output logic     busy,
  output logic     done
);

  ctrl_state_t      state;
  ctrl_state_t      state_next;
  logic [len_w-1:0] pkt_cnt;
  logic [len_w-1:0] pkt_cnt_inc;
  logic             shot_done;

  assign pkt_cnt_inc = pkt_cnt + 1'b1;

  // Last packet of a single-shot run is leaving the packetizer.
  assign shot_done = !cfg.continuous && pkt_done && (pkt_cnt_inc == cfg.pkt_count);

  // ============================================================
  // Next state.
  // ============================================================

  always_comb
  begin
    state_next = state;
    case (state)
      st_idle:
      begin
        if (start)
        begin
          state_next = st_run;
        end
      end
      st_run:
      begin
        if (stop || shot_done)
        begin
          state_next = st_drain;
        end
      end
      st_drain:
      begin
        // Never stop in the middle of a packet.
        if (!pkt_active)
        begin
          state_next = st_idle;
        end
      end
      default:
      begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state   <= st_idle;
      pkt_cnt <= '0;
      done    <= 1'b0;
    end
    else
    begin
      state <= state_next;
      done  <= (state == st_drain) && !pkt_active;
      if ((state == st_idle) && start)
      begin
        pkt_cnt <= '0;
      end
      else if ((state == st_run) && pkt_done)
      begin
        pkt_cnt <= pkt_cnt_inc;
      end
    end
  end

  // Decimator keeps feeding while the open packet drains.
  assign run        = (state == st_run);
  assign capture_en = (state != st_idle);
  assign busy       = (state != st_idle);

endmodule

// File: src/acq_pkg.sv
package acq_pkg;

  // ============================================================
  // Widths.
  // ============================================================

  localparam int sample_w = 16;
  localparam int len_w    = 16;
  localparam int shift_w  = 3;

  // Room for sixteen full-scale samples.
  localparam int acc_w    = sample_w + 4;

  // ============================================================
  // Configuration and stream types.
  // ============================================================

  // Held steady while a run is in progress.
  typedef struct packed {
    logic [len_w-1:0]   packet_len_m1;
    logic [len_w-1:0]   pkt_count;
    logic [shift_w-1:0] decim_shift;
    logic               continuous;
  } acq_cfg_t;

  typedef struct packed {
    logic [sample_w-1:0] data;
    logic                last;
  } beat_t;

  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_run   = 2'd1,
    st_drain = 2'd2
  } ctrl_state_t;

endpackage

// File: src/acq_top.sv
`timescale 1ns/1ns

module acq_top
  import acq_pkg::*;
#(
  parameter int fifo_depth_log2 = 3
)
(
  input  logic                aclk,
  input  logic                aresetn,

  input  logic [sample_w-1:0] s_tdata,
  input  logic                s_tvalid,
  output logic                s_tready,

  output beat_t               m_beat,
  output logic                m_tvalid,
  input  logic                m_tready,

  input  acq_cfg_t            cfg,
  input  logic                start,
  input  logic                stop,

  output logic                busy,
  output logic                done
);

  logic  run;
  logic  capture_en;
  logic  pkt_done;
  logic  pkt_active;

  beat_t dec_beat;
  logic  dec_valid;
  logic  dec_ready;

  beat_t pkt_beat;
  logic  pkt_valid;
  logic  pkt_ready;

  acq_control i_control (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .start      (start),
    .stop       (stop),
    .cfg        (cfg),
    .pkt_done   (pkt_done),
    .pkt_active (pkt_active),
    .run        (run),
    .capture_en (capture_en),
    .busy       (busy),
    .done       (done)
  );

  sample_decimator i_decimator (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .capture_en  (capture_en),
    .decim_shift (cfg.decim_shift),
    .s_tdata     (s_tdata),
    .s_tvalid    (s_tvalid),
    .s_tready    (s_tready),
    .out_beat    (dec_beat),
    .out_valid   (dec_valid),
    .out_ready   (dec_ready)
  );

  axis_packetizer i_packetizer (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .run           (run),
    .packet_len_m1 (cfg.packet_len_m1),
    .s_beat        (dec_beat),
    .s_tvalid      (dec_valid),
    .s_tready      (dec_ready),
    .m_beat        (pkt_beat),
    .m_tvalid      (pkt_valid),
    .m_tready      (pkt_ready),
    .pkt_active    (pkt_active),
    .pkt_done      (pkt_done)
  );

  packet_fifo #(
    .depth_log2 (fifo_depth_log2)
  ) i_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_beat   (pkt_beat),
    .in_valid  (pkt_valid),
    .in_ready  (pkt_ready),
    .out_beat  (m_beat),
    .out_valid (m_tvalid),
    .out_ready (m_tready)
  );

endmodule

// File: src/axis_packetizer.sv
`timescale 1ns/1ns

module axis_packetizer
  import acq_pkg::*;
(
  input  logic             aclk,
  input  logic             aresetn,

  input  logic             run,
  input  logic [len_w-1:0] packet_len_m1,

  input  beat_t            s_beat,
  input  logic             s_tvalid,
  output logic             s_tready,

  output beat_t            m_beat,
  output logic             m_tvalid,
  input  logic             m_tready,

  output logic             pkt_active,
  output logic             pkt_done
);

  logic [len_w-1:0] cntr;
  logic [len_w-1:0] cntr_next;
  logic             enbl;
  logic             enbl_next;
  logic             tlast;
  logic             xfer;

  assign tlast = (cntr == packet_len_m1);
  assign xfer  = enbl && s_tvalid && m_tready;

  // ============================================================
  // Beat counter and packet enable.
  // ============================================================

  always_comb
  begin
    cntr_next = cntr;
    enbl_next = enbl;

    // A new packet only opens between packets.
    if (!enbl && run)
    begin
      enbl_next = 1'b1;
    end

    if (xfer)
    begin
      if (tlast)
      begin
        cntr_next = '0;
        enbl_next = 1'b0;
      end
      else
      begin
        cntr_next = cntr + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      cntr <= '0;
      enbl <= 1'b0;
    end
    else
    begin
      cntr <= cntr_next;
      enbl <= enbl_next;
    end
  end

  // Zero-latency pass-through, gated by the enable.
  assign m_beat.data = s_beat.data;
  assign m_beat.last = s_beat.last || (enbl && tlast);
  assign m_tvalid    = enbl && s_tvalid;
  assign s_tready    = enbl && m_tready;

  assign pkt_active = enbl;
  assign pkt_done   = xfer && tlast;

endmodule

// File: src/packet_fifo.sv
`timescale 1ns/1ns

module packet_fifo
  import acq_pkg::*;
#(
  parameter int depth_log2 = 3
)
(
  input  logic  aclk,
  input  logic  aresetn,

  input  beat_t in_beat,
  input  logic  in_valid,
  output logic  in_ready,

  output beat_t out_beat,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int depth = 1 << depth_log2;

  beat_t                 mem [depth];
  logic [depth_log2-1:0] wr_ptr;
  logic [depth_log2-1:0] rd_ptr;
  logic [depth_log2:0]   count;
  logic                  wr_en;
  logic                  rd_en;

  assign in_ready  = (count != depth[depth_log2:0]);
  assign out_valid = (count != '0);

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  // ============================================================
  // Storage.
  // ============================================================

  always_ff @(posedge aclk)
  begin
    if (wr_en)
    begin
      mem[wr_ptr] <= in_beat;
    end
  end

  assign out_beat = mem[rd_ptr];

  // ============================================================
  // Pointers and occupancy.
  // ============================================================

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: src/sample_decimator.sv
`timescale 1ns/1ns

module sample_decimator
  import acq_pkg::*;
(
  input  logic                aclk,
  input  logic                aresetn,

  input  logic                capture_en,
  input  logic [shift_w-1:0]  decim_shift,

  input  logic [sample_w-1:0] s_tdata,
  input  logic                s_tvalid,
  output logic                s_tready,

  output beat_t               out_beat,
  output logic                out_valid,
  input  logic                out_ready
);

  localparam int cnt_w = acc_w - sample_w;

  logic [acc_w-1:0]    acc;
  logic [acc_w-1:0]    sum;
  logic [cnt_w-1:0]    cnt;
  logic [cnt_w-1:0]    grp_m1;
  logic [sample_w-1:0] res_data;
  logic                res_valid;
  logic                grp_end;
  logic                take;

  // 2^shift - 1, built as a mask.
  assign grp_m1  = ~({cnt_w{1'b1}} << decim_shift);
  assign grp_end = (cnt == grp_m1);

  // Stall only when a finished group would overwrite an unsent result.
  assign s_tready = capture_en && !(res_valid && grp_end);
  assign take     = s_tvalid && s_tready;
  assign sum      = acc + acc_w'(s_tdata);

  always_ff @(posedge aclk)
  begin
    if (!aresetn || !capture_en)
    begin
      acc       <= '0;
      cnt       <= '0;
      res_valid <= 1'b0;
    end
    else
    begin
      if (out_valid && out_ready)
      begin
        res_valid <= 1'b0;
      end
      if (take)
      begin
        if (grp_end)
        begin
          acc       <= '0;
          cnt       <= '0;
          res_valid <= 1'b1;
        end
        else
        begin
          acc <= sum;
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // Floor average.
  always_ff @(posedge aclk)
  begin
    if (take && grp_end)
    begin
      res_data <= sample_w'(sum >> decim_shift);
    end
  end

  assign out_beat  = '{data: res_data, last: 1'b0};
  assign out_valid = res_valid;

endmodule

// File: tests/acq_assertions.sv
`timescale 1ns/1ns

module acq_assertions
  import acq_pkg::*;
(
  input logic        aclk,
  input logic        aresetn,
  input beat_t       m_beat,
  input logic        m_tvalid,
  input logic        m_tready,
  input logic        start,
  input logic        busy,
  input logic        done,
  input ctrl_state_t state
);

  // A stalled output beat holds its data until the sink takes it.
  a_out_stable : assert property (
    @(posedge aclk) disable iff (!aresetn)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_beat))
  ) else $error("m_beat changed or m_tvalid fell while the sink stalled");

  // Control stays idle and not busy until a start arrives.
  a_idle_not_busy : assert property (
    @(posedge aclk) disable iff (!aresetn)
    ((state == st_idle) && !start) |=> !busy
  ) else $error("busy rose while control was idle without a start");

  // Done is a single pulse at the end of a drain.
  a_done_pulse : assert property (
    @(posedge aclk) disable iff (!aresetn)
    done |=> !done
  ) else $error("done held for more than one cycle");

  a_done_after_drain : assert property (
    @(posedge aclk) disable iff (!aresetn)
    done |-> ($past(state) == st_drain)
  ) else $error("done pulsed without a preceding drain");

endmodule

bind acq_top acq_assertions i_assertions (
  .aclk     (aclk),
  .aresetn  (aresetn),
  .m_beat   (m_beat),
  .m_tvalid (m_tvalid),
  .m_tready (m_tready),
  .start    (start),
  .busy     (busy),
  .done     (done),
  .state    (i_control.state)
);

// File: tests/acq_tb.sv
`timescale 1ns/1ns

module acq_tb
  import acq_pkg::*;
();

  localparam int          fifo_depth_log2 = 3;
  localparam logic [31:0] seed            = 32'h66e9cce0;

  // Worst-case samples over all runs, four cycles each at most.
  localparam int sample_budget = 12 + 180 + 40 + 200 + 44;
  localparam int cycle_limit   = sample_budget * 4 + 1000;

  logic                aclk     = 1'b0;
  logic                aresetn  = 1'b0;
  logic [sample_w-1:0] s_tdata  = '0;
  logic                s_tvalid = 1'b0;
  logic                s_tready;
  beat_t               m_beat;
  logic                m_tvalid;
  logic                m_tready = 1'b0;
  acq_cfg_t            cfg      = '0;
  logic                start    = 1'b0;
  logic                stop     = 1'b0;
  logic                busy;
  logic                done;

  int ready_pct = 100;
  int cycle_cnt = 0;
  int errors    = 0;
  int tests     = 0;
  int in_q[$];
  int out_data[$];
  bit out_last[$];

  acq_top #(
    .fifo_depth_log2 (fifo_depth_log2)
  ) i_dut (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .m_beat   (m_beat),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .cfg      (cfg),
    .start    (start),
    .stop     (stop),
    .busy     (busy),
    .done     (done)
  );

  initial
  begin
    forever #5 aclk = ~aclk;
  end

  // ============================================================
  // Stream drivers and monitors.
  // ============================================================

  // Source keeps a pending sample stable until it is taken.
  always @(posedge aclk)
  begin
    if (!aresetn)
    begin
      s_tvalid <= 1'b0;
      m_tready <= 1'b0;
    end
    else
    begin
      if (!s_tvalid || s_tready)
      begin
        s_tvalid <= ($urandom % 4) != 0;
        s_tdata  <= sample_w'($urandom);
      end
      m_tready <= ($urandom % 100) < ready_pct;
    end
  end

  always @(posedge aclk)
  begin
    if (aresetn && s_tvalid && s_tready)
    begin
      in_q.push_back(int'(s_tdata));
    end
    if (aresetn && m_tvalid && m_tready)
    begin
      out_data.push_back(int'(m_beat.data));
      out_last.push_back(m_beat.last);
    end
  end

  always @(posedge aclk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ============================================================
  // Reference model and run control.
  // ============================================================

  // Output must be a whole-packet prefix of the group averages.
  function automatic int check_output(input int in_base, input int out_base,
                                      input int shift, input int plen,
                                      input int exp_pkts);
    int errs;
    int grp;
    int n_groups;
    int n_out;
    int sum;
    int exp_data;
    bit exp_last;
    int i;
    int k;
    errs     = 0;
    grp      = 1 << shift;
    n_groups = (in_q.size() - in_base) >> shift;
    n_out    = out_data.size() - out_base;
    if (exp_pkts > 0 && n_out != exp_pkts * plen)
    begin
      $display("[FAIL] %0t beat count: expected %0d, got %0d", $time, exp_pkts * plen, n_out);
      errs++;
    end
    // A stopped run still finishes the packet that was open.
    if (exp_pkts == 0 && n_out < plen)
    begin
      $display("Continuous run ended without a complete packet");
      errs++;
    end
    if (n_out % plen != 0)
    begin
      $display("Output ended inside a packet after %0d beats", n_out);
      errs++;
    end
    if (n_out > n_groups)
    begin
      $display("Got %0d beats from only %0d complete sample groups", n_out, n_groups);
      errs++;
      n_out = n_groups;
    end
    for (i = 0; i < n_out; i++)
    begin
      sum = 0;
      for (k = 0; k < grp; k++)
      begin
        sum += in_q[in_base + i * grp + k];
      end
      exp_data = sum >> shift;
      exp_last = ((i + 1) % plen) == 0;
      if (out_data[out_base + i] != exp_data)
      begin
        $display("[FAIL] %0t m_beat.data (beat %0d): expected %04h, got %04h",
                 $time, i, exp_data, out_data[out_base + i]);
        errs++;
      end
      if (out_last[out_base + i] != exp_last)
      begin
        $display("[FAIL] %0t m_beat.last (beat %0d): expected %0b, got %0b",
                 $time, i, exp_last, out_last[out_base + i]);
        errs++;
      end
    end
    return errs;
  endfunction

  task automatic run_capture(input int shift, input int plen, input int count,
                             input bit cont, input int pct,
                             output int n_beats, output int errs);
    int in_base;
    int out_base;
    int stop_after;
    errs = 0;
    @(posedge aclk);
    cfg       <= '{packet_len_m1: len_w'(plen - 1), pkt_count: len_w'(count),
                   decim_shift: shift_w'(shift), continuous: cont};
    ready_pct <= pct;
    @(posedge aclk);
    in_base  = in_q.size();
    out_base = out_data.size();
    start   <= 1'b1;
    @(posedge aclk);
    start <= 1'b0;
    if (cont)
    begin
      stop_after = 30 + int'($urandom % 121);
      repeat (stop_after) @(posedge aclk);
      // Continuous mode ignores the packet count.
      if (busy !== 1'b1)
      begin
        $display("Continuous run ended before the stop pulse");
        errs++;
      end
      stop <= 1'b1;
      @(posedge aclk);
      stop <= 1'b0;
    end
    do
    begin
      @(posedge aclk);
    end
    while (done !== 1'b1);
    if (busy !== 1'b0)
    begin
      $display("[FAIL] %0t busy: expected 0, got %b", $time, busy);
      errs++;
    end
    // Let the FIFO empty into the sink.
    while (m_tvalid === 1'b1)
    begin
      @(posedge aclk);
    end
    n_beats = out_data.size() - out_base;
    errs += check_output(in_base, out_base, shift, plen, cont ? 0 : count);
  endtask

  task automatic report_test(input string name, input int n_beats, input int errs);
    tests++;
    errors += errs;
    $display("Test %0d %s: %0d beats, %0d errors", tests, name, n_beats, errs);
  endtask

  initial
  begin
    int n;
    int e;
    int n_sum;
    int e_sum;
    int shift;
    void'($urandom(seed));
    repeat (16) @(posedge aclk);
    aresetn <= 1'b1;
    repeat (4) @(posedge aclk);

    run_capture(0, 4, 3, 1'b0, 100, n, e);
    report_test("single-shot pass-through", n, e);

    n_sum = 0;
    e_sum = 0;
    for (shift = 1; shift <= 4; shift++)
    begin
      run_capture(shift, 3, 2, 1'b0, 100, n, e);
      n_sum += n;
      e_sum += e;
    end
    report_test("decimation shifts 1 to 4", n_sum, e_sum);

    run_capture(1, 5, 4, 1'b0, 50, n, e);
    report_test("sink back-pressure", n, e);

    run_capture(2, 4, 1, 1'b1, 70, n, e);
    report_test("continuous with stop", n, e);

    run_capture(2, 3, 2, 1'b0, 80, n, e);
    n_sum = n;
    e_sum = e;
    run_capture(1, 5, 2, 1'b0, 80, n, e);
    report_test("back-to-back runs", n_sum + n, e_sum + e);

    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
